// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Byte address of an instruction
    typedef logic [31:0] t_paddr;

    // Raw 32-bit instruction word
    typedef logic [31:0] t_rv_instr;

    // Sequence number of a delivered instruction, wraps around
    typedef logic [15:0] t_fetch_id;

    // Major opcode field, bits 6:0 of the instruction
    typedef logic [6:0] t_opcode;

    // MISC-MEM opcode (FENCE class), used as the halt marker
    localparam t_opcode RV_OP_MISC = 7'b000_1111;

    // Fetch FSM states
    typedef enum logic [2:0] {
        IDLE,
        REQ,
        PEND,
        PEND_STALL,
        HALT
    } t_fetch_state;

endpackage

`default_nettype wire

// ==== src/mem_if.sv ====
`default_nettype none

interface mem_if
    import fetch_pkg::*;
();

    // Request, one word per cycle at most
    logic      req_valid;
    t_paddr    req_addr;

    // Response, one cycle after the request
    logic      rsp_valid;
    t_rv_instr rsp_data;
    t_paddr    rsp_addr;

    modport requester (
        output req_valid,
        output req_addr,
        input  rsp_valid
    );

    modport responder (
        input  req_valid,
        input  req_addr,
        output rsp_valid,
        output rsp_data,
        output rsp_addr
    );

    // Passive view of the response side
    modport monitor (
        input rsp_valid,
        input rsp_data,
        input rsp_addr
    );

endinterface

`default_nettype wire

// ==== src/instr_rom.sv ====
`default_nettype none

module instr_rom
    import fetch_pkg::*;
#(
    parameter int ROM_DEPTH = 256
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      load_en,
    input  t_paddr    load_addr,
    input  t_rv_instr load_data,
    mem_if.responder  mem
);

    localparam int IDX_W = $clog2(ROM_DEPTH);

    t_rv_instr rom [ROM_DEPTH];

    logic [IDX_W-1:0] load_idx;
    logic [IDX_W-1:0] req_idx;

    // Word index, byte offset dropped
    assign load_idx = load_addr[IDX_W+1:2];
    assign req_idx  = mem.req_addr[IDX_W+1:2];

    // Load port
    always_ff @(posedge clk) begin
        if (load_en) begin
            rom[load_idx] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem.rsp_valid <= 1'b0;
        end else begin
            mem.rsp_valid <= mem.req_valid;
        end
    end

    // Read data and echoed address, one cycle after the request
    always_ff @(posedge clk) begin
        if (mem.req_valid) begin
            mem.rsp_data <= rom[req_idx];
            mem.rsp_addr <= mem.req_addr;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_buffer.sv ====
`default_nettype none

module fetch_buffer
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    mem_if.monitor    mem,
    input  logic      stall,
    output logic      valid,
    output t_rv_instr instr,
    output t_paddr    pc,
    output t_fetch_id fetch_id,
    output logic      deliver,
    output logic      deliver_halt,
    output logic      held
);

    t_rv_instr hold_instr;
    t_paddr    hold_pc;
    t_opcode   opcode;

    // Response waiting behind a stall
    always_ff @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else if (mem.rsp_valid && stall) begin
            held <= 1'b1;
        end else if (deliver) begin
            held <= 1'b0;
        end
    end

    // Copy of the last response
    always_ff @(posedge clk) begin
        if (mem.rsp_valid) begin
            hold_instr <= mem.rsp_data;
            hold_pc    <= mem.rsp_addr;
        end
    end

    // Live response passes straight through unless one is held
    assign valid = held | mem.rsp_valid;
    assign instr = held ? hold_instr : mem.rsp_data;
    assign pc    = held ? hold_pc    : mem.rsp_addr;

    assign deliver = valid & ~stall;

    // Halt marker check on the accepted word
    assign opcode       = instr[6:0];
    assign deliver_halt = deliver & (opcode == RV_OP_MISC);

    // Count of accepted instructions
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_id <= '0;
        end else if (deliver) begin
            fetch_id <= fetch_id + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_ctrl.sv ====
`default_nettype none

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     run,
    mem_if.requester mem,
    input  logic     deliver,
    input  logic     deliver_halt,
    input  logic     held,
    output logic     halted
);

    t_fetch_state state;
    t_fetch_state state_nxt;
    t_paddr       pc;
    logic         issue;
    logic         accept_halt;

    assign accept_halt = deliver & deliver_halt;

    // First request from REQ, then one behind each accepted instruction
    assign issue = (state == REQ) | (deliver & ~deliver_halt);

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE: begin
                if (run) begin
                    state_nxt = REQ;
                end
            end
            REQ: begin
                state_nxt = PEND;
            end
            PEND: begin
                if (accept_halt) begin
                    state_nxt = HALT;
                end else if (mem.rsp_valid && !deliver) begin
                    // Response parked in the buffer
                    state_nxt = PEND_STALL;
                end
            end
            PEND_STALL: begin
                if (accept_halt) begin
                    state_nxt = HALT;
                end else if (held && deliver) begin
                    state_nxt = PEND;
                end
            end
            HALT: begin
                state_nxt = HALT;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // PC steps one word per request
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (issue) begin
            pc <= pc + 32'd4;
        end
    end

    assign mem.req_valid = issue;
    assign mem.req_addr  = pc;

    assign halted = (state == HALT);

endmodule

`default_nettype wire

// ==== src/fetch_top.sv ====
`default_nettype none

module fetch_top
    import fetch_pkg::*;
#(
    parameter int ROM_DEPTH = 256
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  logic      load_en,
    input  t_paddr    load_addr,
    input  t_rv_instr load_data,
    input  logic      stall,
    output logic      valid,
    output t_rv_instr instr,
    output t_paddr    pc,
    output t_fetch_id fetch_id,
    output logic      halted
);

    logic deliver;
    logic deliver_halt;
    logic held;

    mem_if mem ();

    fetch_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .mem          (mem.requester),
        .deliver      (deliver),
        .deliver_halt (deliver_halt),
        .held         (held),
        .halted       (halted)
    );

    fetch_buffer u_buffer (
        .clk          (clk),
        .reset        (reset),
        .mem          (mem.monitor),
        .stall        (stall),
        .valid        (valid),
        .instr        (instr),
        .pc           (pc),
        .fetch_id     (fetch_id),
        .deliver      (deliver),
        .deliver_halt (deliver_halt),
        .held         (held)
    );

    instr_rom #(
        .ROM_DEPTH (ROM_DEPTH)
    ) u_rom (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .mem       (mem.responder)
    );

endmodule

`default_nettype wire

// ==== tb/fetch_sva.sv ====
`default_nettype none

module fetch_sva
    import fetch_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      stall,
    input logic      valid,
    input t_rv_instr instr,
    input t_paddr    pc,
    input t_fetch_id fetch_id,
    input logic      halted
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed assertions
    int n_fail = 0;

    // Stalled output is frozen for the next cycle
    property p_hold_under_stall;
        @(posedge clk) disable iff (reset)
            valid && stall |=> valid && $stable(instr) && $stable(pc) && $stable(fetch_id);
    endproperty

    a_hold_under_stall: assert property (p_hold_under_stall)
        else begin
            $error("Stalled instruction changed or dropped");
            n_fail++;
        end

    // Accepted MISC-MEM word
    a_halt_follows: assert property (@(posedge clk) disable iff (reset)
        valid && !stall && instr[6:0] == 7'b000_1111 |=> halted)
        else begin
            $error("halted did not rise after the halt marker was accepted");
            n_fail++;
        end

    a_silent_after_halt: assert property (@(posedge clk) disable iff (reset)
        halted |-> !valid)
        else begin
            $error("valid raised after halt");
            n_fail++;
        end

endmodule

bind fetch_top fetch_sva u_sva (.*);

`default_nettype wire

// ==== tb/fetch_tb.sv ====
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACCEPT_TIMEOUT = 64;
    localparam int QUIET_CYCLES   = 8;
    localparam int MAX_WORDS      = 256;

    logic      clk = 1'b0;
    logic      reset;
    logic      run;
    logic      load_en;
    t_paddr    load_addr;
    t_rv_instr load_data;
    logic      stall;
    logic      valid;
    t_rv_instr instr;
    t_paddr    pc;
    t_fetch_id fetch_id;
    logic      halted;

    int        seed = 32'he1bd_9547;
    int        n_mismatch = 0;
    int        n_timeout = 0;
    int        n_other = 0;
    int        n_tests = 0;
    logic      stop_run = 1'b0;
    string     test_name;
    t_rv_instr prog [MAX_WORDS];

    fetch_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .stall     (stall),
        .valid     (valid),
        .instr     (instr),
        .pc        (pc),
        .fetch_id  (fetch_id),
        .halted    (halted)
    );

    always #4 clk = ~clk;

    task automatic check_instr(input t_rv_instr exp, input t_rv_instr act);
        if (act !== exp) begin
            $display("Mismatch in %s: instr expected %h, actual %h", test_name, exp, act);
            n_mismatch++;
        end
    endtask

    task automatic check_pc(input t_paddr exp, input t_paddr act);
        if (act !== exp) begin
            $display("Mismatch in %s: pc expected %h, actual %h", test_name, exp, act);
            n_mismatch++;
        end
    endtask

    task automatic check_id(input t_fetch_id exp, input t_fetch_id act);
        if (act !== exp) begin
            $display("Mismatch in %s: fetch_id expected %0d, actual %0d", test_name, exp, act);
            n_mismatch++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch in %s: %s expected %b, actual %b", test_name, what, exp, act);
            n_mismatch++;
        end
    endtask

    // True with a probability of pct percent
    function automatic logic roll_stall(input int pct);
        int r;
        r = $random(seed);
        return ((r % 100 + 100) % 100) < pct;
    endfunction

    task automatic run_program(input int pct, input int count);
        int   i;
        int   k;
        int   waited;
        logic s;
        logic done;
        k = 0;
        waited = 0;
        done = 1'b0;
        reset = 1'b1;
        run = 1'b0;
        stall = 1'b0;
        repeat (5) @(negedge clk);
        check_flag("valid after reset", 1'b0, valid);
        check_flag("halted after reset", 1'b0, halted);
        reset = 1'b0;
        for (i = 0; i < count; i++) begin
            load_en = 1'b1;
            load_addr = t_paddr'(i * 4);
            load_data = prog[i];
            @(negedge clk);
        end
        load_en = 1'b0;
        run = 1'b1;
        // Outputs are sampled before stall changes on the same falling edge
        while (!done) begin
            @(negedge clk);
            s = roll_stall(pct);
            if (pct == 0 && k > 0) begin
                check_flag("valid in no-stall stream", 1'b1, valid);
            end
            if (valid && !s) begin
                check_instr(prog[k], instr);
                check_pc(t_paddr'(k * 4), pc);
                check_id(t_fetch_id'(k), fetch_id);
                waited = 0;
                done = (prog[k][6:0] == 7'b000_1111) || (k + 1 >= count);
                k++;
            end else begin
                waited++;
                if (waited > ACCEPT_TIMEOUT) begin
                    $display("Timeout in %s: no instruction accepted for %0d cycles",
                             test_name, ACCEPT_TIMEOUT);
                    n_timeout++;
                    stop_run = 1'b1;
                    done = 1'b1;
                end
            end
            stall = s;
        end
        if (!stop_run) begin
            @(negedge clk);
            check_flag("halted after marker", 1'b1, halted);
            // Marker is the last word, so the count is its position plus one
            check_id(t_fetch_id'(count), fetch_id);
            repeat (QUIET_CYCLES) begin
                check_flag("valid after halt", 1'b0, valid);
                check_flag("halted held", 1'b1, halted);
                stall = roll_stall(pct);
                @(negedge clk);
            end
        end
        run = 1'b0;
        stall = 1'b0;
    endtask

    initial begin
        int    fd;
        int    code;
        int    pct;
        int    count;
        int    i;
        int    n_assert;
        string tok;
        string line;
        reset = 1'b1;
        run = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        stall = 1'b0;
        fd = $fopen("tb/fetch_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the data file tb/fetch_tests.txt");
            n_other++;
        end else begin
            while (!stop_run && $fscanf(fd, "%s", tok) == 1) begin
                if (tok.getc(0) == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    test_name = tok;
                    code = $fscanf(fd, "%d %d", pct, count);
                    if (code != 2 || count < 1 || count > MAX_WORDS) begin
                        $display("Unreadable test header for %s in the data file", tok);
                        n_other++;
                        stop_run = 1'b1;
                    end else begin
                        for (i = 0; i < count; i++) begin
                            code = $fscanf(fd, "%h", prog[i]);
                        end
                        n_tests++;
                        run_program(pct, count);
                    end
                end
            end
            $fclose(fd);
        end
        if (n_tests == 0) begin
            $display("No test was run from the data file");
            n_other++;
        end
        n_assert = dut0.u_sva.n_fail;
        $display("Tests %0d: %0d mismatches, %0d timeouts, %0d assertion failures, %0d other errors",
                 n_tests, n_mismatch, n_timeout, n_assert, n_other);
        if (n_mismatch + n_timeout + n_assert + n_other == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/fetch_tests.txt ====
# name stall_percent word_count, then word_count hex instruction words
# each program ends with a MISC-MEM word (FENCE) that halts fetching
no_stall 0 6
00500093
00700113
002081b3
40110233
123452b7
0ff0000f
light_stall 25 7
00a00093
0032a023
0002a303
001343b3
00500093
00700113
0000100f
heavy_stall 70 5
123452b7
002081b3
40110233
0002a303
0ff0000f
halt_only 40 1
0000100f

// ==== compile.f ====
src/fetch_pkg.sv
src/mem_if.sv
src/instr_rom.sv
src/fetch_buffer.sv
src/fetch_ctrl.sv
src/fetch_top.sv
tb/fetch_sva.sv
tb/fetch_tb.sv
